/* compile.f */
host_cmd_pkg.sv
spi_frame_pkg.sv
adc_cmd_decoder.sv
spi_cmd_queue.sv
adc_spi_shifter.sv
adc_spi_intf_top.sv
adc_spi_slave_model.sv
tb_adc_spi_intf.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_adc_spi_intf
FILELIST = compile.f

BUILD    = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL), run $(TOP), log in $(LOG)"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	-./$(BUILD)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then \
		echo "test: FAIL"; exit 1; \
	fi
	@if ! grep -q "Regression passed" $(LOG); then \
		echo "test: simulation ended without a result line"; exit 1; \
	fi
	@echo "test: PASS"

clean:
	rm -rf $(BUILD) $(LOG)

/* tb_adc_spi_intf.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_adc_spi_intf import host_cmd_pkg::*, spi_frame_pkg::*;
();

    // write/read pairs, burst length, reads after the ADC reset
    localparam int N_PAIRS  = 8;
    localparam int N_BURST  = 12;
    localparam int N_CLEAR  = 4;
    localparam int N_CMDS   = 2 * N_PAIRS + N_BURST + N_CLEAR;
    localparam int MAX_CYC  = 2 * N_CMDS * 60;
    // sdenb low time of one frame in clock cycles
    localparam int LOW_CYC  = 2 * FRAME_W;

    logic              slow_clk;
    logic              resetS;
    host_cmd_s         host_word;
    logic              sdi;
    logic [READ_W-1:0] read_data;
    logic              read_valid;
    logic              busy;
    logic              sclk;
    logic              sdio;
    logic              sdenb;
    logic              sresetb;
    int                model_frames;
    int                model_errors;

    // shadow of the ADC registers and the reads still outstanding
    logic [REG_DATA_W-1:0] shadow [128];
    logic [READ_W-1:0]     exp_q [$];
    logic [READ_W-1:0]     exp_val;
    logic [6:0]            addr_list [N_PAIRS];
    int data_errors;
    int frame_errors;
    int count_errors;
    int cmds_issued;
    int reads_issued;
    int rd_pulses;
    int frames_seen;
    int full_cycles;
    int low_cycles;
    int rise_cnt;
    logic sdenb_prev;
    logic sclk_prev;

    adc_spi_intf_top #(
        .QUEUE_DEPTH (4)
    ) uut (
        .slow_clk   (slow_clk),
        .resetS     (resetS),
        .host_word  (host_word),
        .sdi        (sdi),
        .read_data  (read_data),
        .read_valid (read_valid),
        .busy       (busy),
        .sclk       (sclk),
        .sdio       (sdio),
        .sdenb      (sdenb),
        .sresetb    (sresetb)
    );

    adc_spi_slave_model u_model (
        .sclk         (sclk),
        .sdio         (sdio),
        .sdenb        (sdenb),
        .sresetb      (sresetb),
        .sdi          (sdi),
        .frames_done  (model_frames),
        .frame_errors (model_errors)
    );

    initial slow_clk = 1'b0;
    always #20 slow_clk = ~slow_clk;

    //**********************************************************
    // reference model
    //**********************************************************

    // a write updates the shadow, a read returns it zero extended
    function automatic logic [READ_W-1:0] expected_result(input logic rd,
        input logic [6:0] addr, input logic [REG_DATA_W-1:0] data);
        if (!rd)
        begin
            shadow[addr] = data;
            return '0;
        end
        return {{(READ_W - REG_DATA_W){1'b0}}, shadow[addr]};
    endfunction

    // sresetb low wipes every ADC register
    function automatic void clear_shadow();
        foreach (shadow[i])
            shadow[i] = '0;
    endfunction

    task automatic tick();
        @(posedge slow_clk);
        #2;
    endtask

    // one access edge, then wait until the decoder slot is free again
    task automatic issue_cmd(input logic rd, input logic [6:0] addr,
        input logic [REG_DATA_W-1:0] data);
        logic [READ_W-1:0] result;
        result = expected_result(rd, addr, data);
        if (rd)
        begin
            exp_q.push_back(result);
            reads_issued++;
        end
        cmds_issued++;
        host_word.rd_wr   = rd;
        host_word.addr    = addr;
        host_word.wr_data = data;
        host_word.access  = 1'b1;
        tick();
        host_word.access  = 1'b0;
        tick();
        // held high under back-pressure while the queue is full
        while (uut.pending)
            tick();
    endtask

    task automatic wait_idle();
        while (busy)
            tick();
    endtask

    // sresetb is a registered copy of the host reset bit
    task automatic check_sresetb(input logic exp);
        assert (sresetb === exp)
        else
        begin
            count_errors++;
            $display("ERROR at %0t: sresetb %b, expected %b", $time, sresetb, exp);
        end
    endtask

    //**********************************************************
    // checkers
    //**********************************************************

    // read results in issue order
    always @(negedge slow_clk)
    begin
        if (resetS === 1'b0 && read_valid)
        begin
            rd_pulses++;
            assert (exp_q.size() != 0)
            else
            begin
                count_errors++;
                $display("read_valid pulsed at %0t with no read outstanding", $time);
            end
            if (exp_q.size() != 0)
            begin
                exp_val = exp_q.pop_front();
                assert (read_data == exp_val)
                else
                begin
                    data_errors++;
                    $display("ERROR at %0t: read_data %h, expected %h",
                             $time, read_data, exp_val);
                end
            end
        end
    end

    // frame length and sclk on the pins, queue fill level
    always @(negedge slow_clk)
    begin
        if (resetS === 1'b0)
        begin
            if (uut.full)
                full_cycles++;
            if (!sdenb)
            begin
                low_cycles++;
                if (sclk && !sclk_prev)
                    rise_cnt++;
            end
            else
            begin
                assert (!sclk)
                else
                begin
                    frame_errors++;
                    $display("ERROR at %0t: sclk high while sdenb is high", $time);
                end
                if (sdenb_prev === 1'b0)
                begin
                    frames_seen++;
                    assert (low_cycles == LOW_CYC && rise_cnt == FRAME_W)
                    else
                    begin
                        frame_errors++;
                        $display("ERROR at %0t: frame of %0d cycles with %0d sclk rises",
                                 $time, low_cycles, rise_cnt);
                    end
                end
                low_cycles = 0;
                rise_cnt   = 0;
            end
        end
        sdenb_prev = sdenb;
        sclk_prev  = sclk;
    end

    // run limit scaled by the command count
    initial
    begin
        repeat (MAX_CYC) @(posedge slow_clk);
        $display("timeout: run did not finish within %0d clock cycles", MAX_CYC);
        $display("Regression failed");
        $finish;
    end

    //**********************************************************
    // stimulus
    //**********************************************************
    initial
    begin
        logic rd;
        $timeformat(-9, 0, " ns", 0);
        void'($urandom(32'hb752_89f0));
        resetS    = 1'b1;
        // ADC held in reset so the model starts cleared
        host_word = '0;
        clear_shadow();
        repeat (5) @(posedge slow_clk);
        #2;
        assert (sdenb && !sclk && !sdio && !read_valid && !busy)
        else
        begin
            count_errors++;
            $display("outputs not at their idle values during reset");
        end
        resetS = 1'b0;
        repeat (3) tick();
        host_word.adc_reset_n = 1'b1;
        tick();

        // random writes, then reads of the same addresses
        for (int i = 0; i < N_PAIRS; i++)
        begin
            addr_list[i] = 7'($urandom);
            issue_cmd(1'b0, addr_list[i], 16'($urandom));
        end
        wait_idle();
        assert (rd_pulses == 0)
        else
        begin
            count_errors++;
            $display("read_valid pulsed during a run of writes only");
        end
        for (int i = 0; i < N_PAIRS; i++)
            issue_cmd(1'b1, addr_list[i], '0);
        wait_idle();

        // mixed burst, fills the queue
        full_cycles = 0;
        for (int i = 0; i < N_BURST; i++)
        begin
            rd = 1'($urandom);
            issue_cmd(rd, 7'($urandom), 16'($urandom));
        end
        wait_idle();
        assert (full_cycles > 0)
        else
        begin
            count_errors++;
            $display("queue never reported full during the burst");
        end

        // pulse the ADC reset, stored values must read back as zero
        host_word.adc_reset_n = 1'b0;
        tick();
        check_sresetb(1'b0);
        repeat (3) tick();
        host_word.adc_reset_n = 1'b1;
        clear_shadow();
        tick();
        check_sresetb(1'b1);
        tick();
        for (int i = 0; i < N_CLEAR; i++)
            issue_cmd(1'b1, addr_list[i], '0);
        wait_idle();
        tick();

        assert (frames_seen == cmds_issued && model_frames == cmds_issued)
        else
        begin
            count_errors++;
            $display("frame count wrong: %0d commands, %0d frames on pins, %0d in model",
                     cmds_issued, frames_seen, model_frames);
        end
        assert (rd_pulses == reads_issued && exp_q.size() == 0)
        else
        begin
            count_errors++;
            $display("read count wrong: %0d reads issued, %0d read_valid pulses",
                     reads_issued, rd_pulses);
        end
        $display("errors: data %0d, framing %0d, count %0d, model %0d",
                 data_errors, frame_errors, count_errors, model_errors);
        if (data_errors + frame_errors + count_errors + model_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* adc_spi_slave_model.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_spi_slave_model import host_cmd_pkg::*, spi_frame_pkg::*;
(
    input  wire  sclk,
    input  wire  sdio,
    input  wire  sdenb,
    input  wire  sresetb,
    output logic sdi,
    output int   frames_done,
    output int   frame_errors
);

    // ADC register file
    logic [REG_DATA_W-1:0] regs [128];
    // bits collected from sdio, MSB first
    spi_frame_u            rx;
    // rd_wr and address, decoded once bit 7 is in
    spi_frame_u            hdr;
    int                    edge_cnt;
    int                    starts;
    bit                    rd_active;
    logic [REG_DATA_W-1:0] rd_word;
    logic [REG_DATA_W-1:0] rd_shift;

    // bit for the next sclk rise, zero outside the data bits of a read
    assign rd_shift = rd_word >> (FRAME_W - 1 - edge_cnt);
    assign sdi      = rd_active & rd_shift[0];

    //**********************************************************
    // serial receive
    //**********************************************************

    // sclk is low when sdenb falls, so sclk tells the two events apart
    always @(posedge sclk or negedge sdenb)
    begin
        if (!sclk)
        begin
            starts    <= starts + 1;
            edge_cnt  <= 0;
            rd_active <= 1'b0;
        end
        else
        begin
            rx.raw   <= {rx.raw[FRAME_W-2:0], sdio};
            edge_cnt <= edge_cnt + 1;
            // address complete on this rise, fetch read data
            if (edge_cnt == FRAME_ADDR_W)
            begin
                hdr.raw   = {rx.raw[FRAME_ADDR_W-1:0], sdio, {FRAME_DATA_W{1'b0}}};
                rd_active <= hdr.fields.rd_wr;
                rd_word   <= regs[hdr.fields.addr];
            end
        end
    end

    // end of frame, or ADC reset pin pulled low
    always @(posedge sdenb or negedge sresetb)
    begin
        if (!sresetb)
        begin
            for (int i = 0; i < 128; i++)
                regs[i] <= '0;
        end
        else if (starts > frames_done)
        begin
            frames_done <= frames_done + 1;
            if (edge_cnt != FRAME_W)
            begin
                frame_errors <= frame_errors + 1;
                $display("framing error: a frame had %0d sclk rising edges instead of %0d",
                         edge_cnt, FRAME_W);
            end
            else if (!rx.fields.rd_wr)
                regs[rx.fields.addr] <= rx.fields.data;
        end
    end

endmodule

`default_nettype wire

/* adc_spi_intf_top.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_spi_intf_top import host_cmd_pkg::*, spi_frame_pkg::*;
#(
    // frames buffered between decoder and shifter
    parameter int QUEUE_DEPTH = 4
)
(
    input  wire               slow_clk,
    input  wire               resetS,
    input  wire host_cmd_s    host_word,
    input  wire               sdi,
    output logic [READ_W-1:0] read_data,
    output logic              read_valid,
    output logic              busy,
    output logic              sclk,
    output logic              sdio,
    output logic              sdenb,
    output logic              sresetb
);

    // decoder to queue
    logic       push_en;
    spi_frame_u push_frame;
    logic       full;
    logic       pending;
    // queue to shifter
    spi_frame_u pop_frame;
    logic       pop_en;
    logic       empty;
    logic       active;

    // work anywhere in the pipeline keeps busy high
    assign busy = pending | active | ~empty;

    //**********************************************************
    // command path
    //**********************************************************
    adc_cmd_decoder u_decoder (
        .slow_clk   (slow_clk),
        .resetS     (resetS),
        .host_word  (host_word),
        .full       (full),
        .push_en    (push_en),
        .push_frame (push_frame),
        .pending    (pending),
        .sresetb    (sresetb)
    );

    spi_cmd_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .slow_clk   (slow_clk),
        .resetS     (resetS),
        .push_en    (push_en),
        .push_frame (push_frame),
        .pop_en     (pop_en),
        .pop_frame  (pop_frame),
        .full       (full),
        .empty      (empty)
    );

    adc_spi_shifter u_shifter (
        .slow_clk   (slow_clk),
        .resetS     (resetS),
        .empty      (empty),
        .pop_frame  (pop_frame),
        .sdi        (sdi),
        .pop_en     (pop_en),
        .sclk       (sclk),
        .sdio       (sdio),
        .sdenb      (sdenb),
        .read_data  (read_data),
        .read_valid (read_valid),
        .active     (active)
    );

endmodule

`default_nettype wire

/* adc_spi_shifter.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_spi_shifter import spi_frame_pkg::*, host_cmd_pkg::*;
(
    input  wire               slow_clk,
    input  wire               resetS,
    input  wire               empty,
    input  wire spi_frame_u   pop_frame,
    input  wire               sdi,
    output logic              pop_en,
    output logic              sclk,
    output logic              sdio,
    output logic              sdenb,
    output logic [READ_W-1:0] read_data,
    output logic              read_valid,
    output logic              active
);

    typedef enum logic [1:0] {ST_IDLE, ST_SHIFT, ST_FINISH} state_e;

    state_e                state;
    // outgoing frame, raw view
    logic [FRAME_W-1:0]    out_sr;
    // last REG_DATA_W bits seen on sdi
    logic [REG_DATA_W-1:0] in_sr;
    logic [BIT_CNT_W-1:0]  bit_cnt;
    // 0 = sclk low half, 1 = sclk high half
    logic                  phase;
    // frame type kept for the end of frame
    logic                  is_read;

    // take the head frame whenever idle
    assign pop_en = (state == ST_IDLE) & ~empty;
    assign active = (state != ST_IDLE);

    //**********************************************************
    // frame FSM and serial pins
    //**********************************************************
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            state      <= ST_IDLE;
            sdenb      <= 1'b1;
            sclk       <= 1'b0;
            sdio       <= 1'b0;
            phase      <= 1'b0;
            bit_cnt    <= '0;
            read_valid <= 1'b0;
            read_data  <= '0;
        end
        else
        begin
            read_valid <= 1'b0;
            case (state)
                ST_IDLE:
                begin
                    // first bit goes out together with sdenb low
                    if (pop_en)
                    begin
                        state   <= ST_SHIFT;
                        sdenb   <= 1'b0;
                        sdio    <= pop_frame.raw[FRAME_W-1];
                        phase   <= 1'b0;
                        bit_cnt <= '0;
                    end
                end
                ST_SHIFT:
                begin
                    phase <= ~phase;
                    if (!phase)
                        sclk <= 1'b1;
                    else
                    begin
                        // falling sclk, move to the next bit
                        sclk    <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == LAST_BIT)
                        begin
                            state <= ST_FINISH;
                            sdenb <= 1'b1;
                            sdio  <= 1'b0;
                        end
                        else
                            sdio <= out_sr[FRAME_W-2];
                    end
                end
                ST_FINISH:
                begin
                    // read result one cycle after sdenb rises
                    state <= ST_IDLE;
                    if (is_read)
                    begin
                        read_data  <= {{(READ_W - REG_DATA_W){1'b0}}, in_sr};
                        read_valid <= 1'b1;
                    end
                end
                default:
                    state <= ST_IDLE;
            endcase
        end
    end

    //**********************************************************
    // shift registers
    //**********************************************************
    always_ff @(posedge slow_clk)
    begin
        if (pop_en)
        begin
            out_sr  <= pop_frame.raw;
            is_read <= pop_frame.fields.rd_wr;
        end
        else if (state == ST_SHIFT && phase)
            out_sr <= {out_sr[FRAME_W-2:0], 1'b0};
        // sdi sampled on the edge that raises sclk
        if (state == ST_SHIFT && !phase)
            in_sr <= {in_sr[REG_DATA_W-2:0], sdi};
    end

    a_cnt_range: assert property (@(posedge slow_clk) disable iff (resetS)
        bit_cnt <= BIT_CNT_W'(FRAME_W));

    // no frame in progress means chip select released
    a_idle_sdenb: assert property (@(posedge slow_clk) disable iff (resetS)
        (state == ST_IDLE) |-> sdenb);

endmodule

`default_nettype wire

/* spi_cmd_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module spi_cmd_queue import spi_frame_pkg::*;
#(
    // power of two, 2 to 8
    parameter int QUEUE_DEPTH
)
(
    input  wire             slow_clk,
    input  wire             resetS,
    input  wire             push_en,
    input  wire spi_frame_u push_frame,
    input  wire             pop_en,
    output spi_frame_u      pop_frame,
    output logic            full,
    output logic            empty
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    // frame storage
    spi_frame_u       mem [QUEUE_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    // occupancy, one bit wider than the pointers
    logic [PTR_W:0]   count;
    logic             do_push;
    logic             do_pop;

    assign full    = (count == (PTR_W + 1)'(QUEUE_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push_en & ~full;
    assign do_pop  = pop_en & ~empty;

    // show-ahead, head of queue always on the output
    assign pop_frame = mem[rd_ptr];

    always_ff @(posedge slow_clk)
    begin
        if (do_push)
            mem[wr_ptr] <= push_frame;
    end

    // pointers wrap on their own since depth is a power of two
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // decoder holds off while the queue is full
    a_no_push_full: assert property (@(posedge slow_clk) disable iff (resetS)
        push_en |-> !full);

    // shifter only pops a valid head
    a_no_pop_empty: assert property (@(posedge slow_clk) disable iff (resetS)
        pop_en |-> !empty);

endmodule

`default_nettype wire

/* adc_cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module adc_cmd_decoder import host_cmd_pkg::*, spi_frame_pkg::*;
(
    input  wire            slow_clk,
    input  wire            resetS,
    input  wire host_cmd_s host_word,
    input  wire            full,
    output logic           push_en,
    output spi_frame_u     push_frame,
    output logic           pending,
    output logic           sresetb
);

    // host word after one register stage
    host_cmd_s host_q;
    // synchronized access bit of the previous cycle
    logic      access_prev;
    logic      access_rise;

    //**********************************************************
    // input stage and edge detect
    //**********************************************************

    // keeps running through reset
    // so an access level held at release counts as already seen
    always_ff @(posedge slow_clk)
    begin
        host_q      <= host_word;
        access_prev <= host_q.access;
    end

    assign access_rise = host_q.access & ~access_prev;

    // ADC reset pin follows the host bit one cycle later
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
            sresetb <= 1'b1;
        else
            sresetb <= host_word.adc_reset_n;
    end

    //**********************************************************
    // single pending slot toward the queue
    //**********************************************************

    // push as soon as the queue has room
    assign push_en = pending & ~full;

    // set on an edge, held under back-pressure
    // edges seen while the slot is taken are dropped
    always_ff @(posedge slow_clk)
    begin
        if (resetS)
            pending <= 1'b0;
        else if (pending)
        begin
            if (!full)
                pending <= 1'b0;
        end
        else if (access_rise)
            pending <= 1'b1;
    end

    // frame captured with the edge, stays put until pushed
    always_ff @(posedge slow_clk)
    begin
        if (!pending && access_rise)
        begin
            push_frame.fields.rd_wr <= host_q.rd_wr;
            push_frame.fields.addr  <= host_q.addr;
            push_frame.fields.data  <= host_q.wr_data;
        end
    end

endmodule

`default_nettype wire

/* spi_frame_pkg.sv */
`default_nettype none

//**********************************************************
// serial frame definitions
//**********************************************************
package spi_frame_pkg;

    // frame layout on sdio, MSB first
    localparam int FRAME_ADDR_W = 7;
    localparam int FRAME_DATA_W = 16;
    localparam int FRAME_W      = 1 + FRAME_ADDR_W + FRAME_DATA_W;

    // bit counter has to reach FRAME_W itself after the last bit
    localparam int BIT_CNT_W = $clog2(FRAME_W + 1);

    // index of the final bit of a frame
    localparam logic [BIT_CNT_W-1:0] LAST_BIT = BIT_CNT_W'(FRAME_W - 1);

    // frame as register fields
    typedef struct packed {
        // 1 = read, 0 = write
        logic                    rd_wr;
        logic [FRAME_ADDR_W-1:0] addr;
        // write data, don't care on reads
        logic [FRAME_DATA_W-1:0] data;
    } spi_frame_fields_s;

    // same 24 bits, built as fields and shifted out as raw bits
    typedef union packed {
        spi_frame_fields_s  fields;
        logic [FRAME_W-1:0] raw;
    } spi_frame_u;

endpackage

`default_nettype wire

/* host_cmd_pkg.sv */
`default_nettype none

//**********************************************************
// host side definitions
//**********************************************************
package host_cmd_pkg;

    // width of one register on the ADC serial port
    localparam int REG_DATA_W = 16;

    // read result word returned to the host
    // upper bits above REG_DATA_W read back as zero
    localparam int READ_W = 32;

    // host command word as written by the controller
    // bit 0 is the access strobe, a rising edge queues one frame
    typedef struct packed {
        // data for a register write
        logic [REG_DATA_W-1:0] wr_data;
        logic                  spare_hi;
        // ADC register address
        logic [6:0]            addr;
        logic [4:0]            spare_lo;
        // active low reset to the ADC
        logic                  adc_reset_n;
        logic                  rd_wr;    // 1 = read, 0 = write
        logic                  access;
    } host_cmd_s;

endpackage

`default_nettype wire
